// File: logic/execPkg.sv
`default_nettype none

package execPkg;

	// ====================
	// widths
	// ====================

	// operand and result width
	localparam int dataWidth = 32;
	// shift amount field
	localparam int shamtWidth = 5;
	// one quotient bit per divider step
	localparam int divSteps = dataWidth;
	// divider step counter width
	localparam int stepWidth = $clog2(divSteps);

	// ====================
	// operations
	// ====================

	typedef enum logic [4:0] {
		// arithmetic
		opAdd, opAddu, opSub, opSubu,
		// bitwise logic
		opAnd, opOr, opXor, opNor,
		// set less than
		opSlt, opSltu,
		// shifts by sa
		opSll, opSrl, opSra,
		// load upper from srcB low half
		opLui,
		// multiply / divide into hi/lo
		opMult, opMultu, opDiv, opDivu,
		// hi/lo moves
		opMfhi, opMflo, opMthi, opMtlo
	} execOpcode_t;

	// one operation as handed over by the outside
	typedef struct packed {
		execOpcode_t opcode;
		logic [dataWidth-1:0] srcA;
		logic [dataWidth-1:0] srcB;
		logic [shamtWidth-1:0] sa;
	} execOp_t;

	// completed operation
	typedef struct packed {
		logic [dataWidth-1:0] value;
		logic overflow;
	} execResult_t;

	// hi/lo register pair
	typedef struct packed {
		logic [dataWidth-1:0] hi;
		logic [dataWidth-1:0] lo;
	} hiLoPair_t;

	// multiply/divide completion
	typedef struct packed {
		hiLoPair_t hiLo;
		// one-cycle pulse
		logic done;
		// low on divide by zero
		logic write;
	} mdDone_t;

endpackage

`default_nettype wire

// File: logic/aluCore.sv
`timescale 1ns/1ps
`default_nettype none

module aluCore (
	input wire execPkg::execOp_t curOp,
	output execPkg::execResult_t aluResult
);

	logic [execPkg::dataWidth-1:0] a;
	logic [execPkg::dataWidth-1:0] b;
	logic [execPkg::dataWidth-1:0] sum;
	logic [execPkg::dataWidth-1:0] diff;
	logic addOvf;
	logic subOvf;
	logic sltBit;
	logic sltuBit;

	assign a = curOp.srcA;
	assign b = curOp.srcB;

	// shared adders for signed and unsigned forms
	assign sum = a + b;
	assign diff = a - b;

	// same operand signs, result sign flipped
	assign addOvf = (a[execPkg::dataWidth-1] == b[execPkg::dataWidth-1])
		&& (sum[execPkg::dataWidth-1] != a[execPkg::dataWidth-1]);
	// opposite operand signs, result sign differs from a
	assign subOvf = (a[execPkg::dataWidth-1] != b[execPkg::dataWidth-1])
		&& (diff[execPkg::dataWidth-1] != a[execPkg::dataWidth-1]);

	assign sltBit = $signed(a) < $signed(b);
	assign sltuBit = a < b;

	always_comb begin
		aluResult = '0;
		case (curOp.opcode)
			// value wraps even when overflow is flagged
			execPkg::opAdd: begin
				aluResult.value = sum;
				aluResult.overflow = addOvf;
			end
			execPkg::opAddu: aluResult.value = sum;
			execPkg::opSub: begin
				aluResult.value = diff;
				aluResult.overflow = subOvf;
			end
			execPkg::opSubu: aluResult.value = diff;
			execPkg::opAnd: aluResult.value = a & b;
			execPkg::opOr: aluResult.value = a | b;
			execPkg::opXor: aluResult.value = a ^ b;
			execPkg::opNor: aluResult.value = ~(a | b);
			execPkg::opSlt: aluResult.value = {{(execPkg::dataWidth-1){1'b0}}, sltBit};
			execPkg::opSltu: aluResult.value = {{(execPkg::dataWidth-1){1'b0}}, sltuBit};
			// shifts act on srcB, as rt in the instruction
			execPkg::opSll: aluResult.value = b << curOp.sa;
			execPkg::opSrl: aluResult.value = b >> curOp.sa;
			execPkg::opSra: aluResult.value = $signed(b) >>> curOp.sa;
			// immediate sits in srcB low half
			execPkg::opLui: aluResult.value = {b[15:0], 16'h0000};
			// mult/div and hi/lo moves are not ours
			default: aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/mulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit (
	input wire clk,
	input wire arstN,
	input wire mdStart,
	input wire execPkg::execOp_t curOp,
	output execPkg::mdDone_t mdOut
);

	localparam int w = execPkg::dataWidth;

	logic isMult;
	logic isSigned;
	logic aNeg;
	logic bNeg;
	logic [2*w-1:0] product;
	logic [w-1:0] aMag;
	logic [w-1:0] bMag;

	// divider state
	logic busy;
	logic [execPkg::stepWidth-1:0] stepCnt;
	logic lastStep;
	logic [w-1:0] remQ;
	logic [w-1:0] quoQ;
	logic [w-1:0] divisorQ;
	logic quoNeg;
	logic remNeg;
	logic divZero;
	logic [w:0] remShift;
	logic [w:0] trial;
	logic [w-1:0] remNext;
	logic [w-1:0] quoNext;

	// output registers
	execPkg::hiLoPair_t hiLoQ;
	logic doneQ;
	logic writeQ;

	// ====================
	// operand decode
	// ====================

	assign isMult = curOp.opcode inside {execPkg::opMult, execPkg::opMultu};
	assign isSigned = curOp.opcode inside {execPkg::opMult, execPkg::opDiv};
	assign aNeg = isSigned && curOp.srcA[w-1];
	assign bNeg = isSigned && curOp.srcB[w-1];

	// extend to 64 bits, low 64 of the product are exact both ways
	assign product = {{w{aNeg}}, curOp.srcA} * {{w{bNeg}}, curOp.srcB};

	// divider runs on magnitudes
	assign aMag = aNeg ? -curOp.srcA : curOp.srcA;
	assign bMag = bNeg ? -curOp.srcB : curOp.srcB;

	// ====================
	// restoring step
	// ====================

	// bring down next dividend bit
	assign remShift = {remQ, quoQ[w-1]};
	assign trial = remShift - {1'b0, divisorQ};
	// borrow means restore
	assign remNext = trial[w] ? remShift[w-1:0] : trial[w-1:0];
	assign quoNext = {quoQ[w-2:0], ~trial[w]};
	assign lastStep = stepCnt == execPkg::stepWidth'(execPkg::divSteps - 1);

	// control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			stepCnt <= '0;
			doneQ <= 1'b0;
			writeQ <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			if (mdStart && isMult) begin
				doneQ <= 1'b1;
				writeQ <= 1'b1;
			end else if (mdStart) begin
				busy <= 1'b1;
				stepCnt <= '0;
			end else if (busy) begin
				stepCnt <= stepCnt + 1'b1;
				if (lastStep) begin
					busy <= 1'b0;
					doneQ <= 1'b1;
					// hi/lo left alone on zero divisor
					writeQ <= !divZero;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (mdStart && isMult) begin
			hiLoQ <= product;
		end else if (mdStart) begin
			remQ <= '0;
			quoQ <= aMag;
			divisorQ <= bMag;
			quoNeg <= aNeg ^ bNeg;
			// remainder follows dividend sign
			remNeg <= aNeg;
			divZero <= curOp.srcB == '0;
		end else if (busy) begin
			remQ <= remNext;
			quoQ <= quoNext;
			if (lastStep) begin
				hiLoQ.hi <= remNeg ? -remNext : remNext;
				hiLoQ.lo <= quoNeg ? -quoNext : quoNext;
			end
		end
	end

	assign mdOut = '{hiLo: hiLoQ, done: doneQ, write: writeQ};

	// sequencer must wait for the divider
	noStartWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
		busy |-> !mdStart);

	doneIsPulse: assert property (@(posedge clk) disable iff (!arstN)
		doneQ |=> !doneQ);

endmodule

`default_nettype wire

// File: logic/writebackStage.sv
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
	input wire clk,
	input wire arstN,
	input wire req,
	input wire execPkg::execOp_t op,
	input wire execPkg::execResult_t aluResult,
	input wire execPkg::mdDone_t mdOut,
	output logic ack,
	output execPkg::execResult_t result,
	output execPkg::execOp_t curOp,
	output logic mdStart
);

	typedef enum logic [1:0] {
		idle,
		issue,
		waitMd,
		hold
	} wbState_t;

	wbState_t state;
	execPkg::hiLoPair_t hiLo;
	execPkg::execResult_t resultNext;
	logic isMulDiv;

	assign isMulDiv = curOp.opcode inside {execPkg::opMult, execPkg::opMultu,
		execPkg::opDiv, execPkg::opDivu};

	// one-cycle kick, only out of issue
	assign mdStart = (state == issue) && isMulDiv;

	// ====================
	// result select
	// ====================

	always_comb begin
		resultNext = '0;
		case (curOp.opcode)
			execPkg::opMfhi: resultNext.value = hiLo.hi;
			execPkg::opMflo: resultNext.value = hiLo.lo;
			// hi/lo writers return zero
			execPkg::opMthi, execPkg::opMtlo,
			execPkg::opMult, execPkg::opMultu,
			execPkg::opDiv, execPkg::opDivu: resultNext = '0;
			default: resultNext = aluResult;
		endcase
	end

	// operand latch, taken once per request
	always_ff @(posedge clk) begin
		if (state == idle && req) begin
			curOp <= op;
		end
	end

	// ====================
	// handshake FSM
	// ====================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			ack <= 1'b0;
			result <= '0;
			hiLo <= '0;
		end else begin
			case (state)
				idle: if (req) state <= issue;
				// alu settles here, mult/div gets mdStart
				issue: state <= waitMd;
				waitMd: begin
					// only mult/div can stall here
					if (!isMulDiv || mdOut.done) begin
						state <= hold;
						ack <= 1'b1;
						result <= resultNext;
						if (mdOut.done && mdOut.write) hiLo <= mdOut.hiLo;
						if (curOp.opcode == execPkg::opMthi) hiLo.hi <= curOp.srcA;
						if (curOp.opcode == execPkg::opMtlo) hiLo.lo <= curOp.srcA;
					end
				end
				// hold ack and result until req drops
				hold: begin
					if (!req) begin
						ack <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// four-phase rule seen from the outside
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// File: logic/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input wire clk,
	input wire arstN,
	input wire req,
	input wire execPkg::execOp_t op,
	output logic ack,
	output execPkg::execResult_t result
);

	execPkg::execOp_t curOp;
	execPkg::execResult_t aluResult;
	execPkg::mdDone_t mdOut;
	logic mdStart;

	// sequencer, owns hi/lo
	writebackStage writebackStage_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.op(op),
		.aluResult(aluResult),
		.mdOut(mdOut),
		.ack(ack),
		.result(result),
		.curOp(curOp),
		.mdStart(mdStart)
	);

	// single-cycle ops
	aluCore aluCore_i (
		.curOp(curOp),
		.aluResult(aluResult)
	);

	// multi-cycle ops
	mulDivUnit mulDivUnit_i (
		.clk(clk),
		.arstN(arstN),
		.mdStart(mdStart),
		.curOp(curOp),
		.mdOut(mdOut)
	);

endmodule

`default_nettype wire

// File: tests/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitTb;

	// handshake wait limit in cycles, divide needs about 35
	localparam int ackTimeout = 100;
	localparam int maxHold = 5;

	logic clk;
	logic arstN;
	logic req;
	execPkg::execOp_t op;
	logic ack;
	execPkg::execResult_t result;

	// stimulus table, one row per index
	string testName[$];
	execPkg::execOp_t testOp[$];
	execPkg::execResult_t testExp[$];

	execUnit execUnit_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.op(op),
		.ack(ack),
		.result(result)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// ====================
	// helpers
	// ====================

	task automatic checkValue(input string name, input logic [32:0] expected,
		input logic [32:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeoutStop(input string what);
		$display("timeout while waiting for %s", what);
		$display("TB FAILED");
		$fatal(1, "handshake timeout");
	endtask

	task automatic addTest(input string name, input execPkg::execOpcode_t opc,
		input logic [31:0] a, input logic [31:0] b, input logic [4:0] sa,
		input logic [31:0] value, input logic ovf);
		execPkg::execOp_t o;
		execPkg::execResult_t e;
		o.opcode = opc;
		o.srcA = a;
		o.srcB = b;
		o.sa = sa;
		e.value = value;
		e.overflow = ovf;
		testName.push_back(name);
		testOp.push_back(o);
		testExp.push_back(e);
	endtask

	// one full four-phase cycle, req held a random number of extra cycles
	task automatic runTest(input int idx);
		int waitCnt;
		int holdCnt;
		@(negedge clk);
		op = testOp[idx];
		req = 1'b1;
		waitCnt = 0;
		while (!ack) begin
			@(negedge clk);
			waitCnt++;
			if (waitCnt > ackTimeout) timeoutStop({"ack to rise in ", testName[idx]});
		end
		checkValue(testName[idx], testExp[idx], result);
		holdCnt = $urandom_range(0, maxHold);
		// ack and result frozen while req stays high
		repeat (holdCnt) begin
			@(negedge clk);
			checkValue({testName[idx], " ack held"}, 33'd1, {32'd0, ack});
			checkValue({testName[idx], " result held"}, testExp[idx], result);
		end
		req = 1'b0;
		waitCnt = 0;
		while (ack) begin
			@(negedge clk);
			waitCnt++;
			if (waitCnt > ackTimeout) timeoutStop({"ack to fall in ", testName[idx]});
		end
	endtask

	// ====================
	// table
	// ====================

	task automatic buildTable();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] q;
		logic [31:0] r;
		logic [32:0] wide;
		logic [63:0] prod;
		logic [4:0] sa;
		// hi/lo cleared by reset
		addTest("mfhiReset", execPkg::opMfhi, 32'h0, 32'h0, 5'd0, 32'h0, 1'b0);
		addTest("mfloReset", execPkg::opMflo, 32'h0, 32'h0, 5'd0, 32'h0, 1'b0);
		// fixed logic, compare, shift, lui
		addTest("andFixed", execPkg::opAnd, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd0, 32'h00f0_1234, 1'b0);
		addTest("orFixed", execPkg::opOr, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd0, 32'hfff0_ffff, 1'b0);
		addTest("xorFixed", execPkg::opXor, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd0, 32'hff00_edcb, 1'b0);
		addTest("norFixed", execPkg::opNor, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd0, 32'h000f_0000, 1'b0);
		addTest("sltFixed", execPkg::opSlt, 32'hffff_fffe, 32'h1, 5'd0, 32'h1, 1'b0);
		addTest("sltuFixed", execPkg::opSltu, 32'hffff_fffe, 32'h1, 5'd0, 32'h0, 1'b0);
		addTest("sllFixed", execPkg::opSll, 32'h0, 32'h81, 5'd4, 32'h810, 1'b0);
		addTest("srlFixed", execPkg::opSrl, 32'h0, 32'h8000_0000, 5'd31, 32'h1, 1'b0);
		addTest("sraFixed", execPkg::opSra, 32'h0, 32'h8000_0000, 5'd4, 32'hf800_0000, 1'b0);
		addTest("luiFixed", execPkg::opLui, 32'h0, 32'h0000_beef, 5'd0, 32'hbeef_0000, 1'b0);
		// signed overflow corners
		addTest("addOvf", execPkg::opAdd, 32'h7fff_ffff, 32'h1, 5'd0, 32'h8000_0000, 1'b1);
		addTest("adduNoOvf", execPkg::opAddu, 32'h7fff_ffff, 32'h1, 5'd0, 32'h8000_0000, 1'b0);
		addTest("subOvf", execPkg::opSub, 32'h8000_0000, 32'h1, 5'd0, 32'h7fff_ffff, 1'b1);
		// random alu operands
		for (int i = 0; i < 4; i++) begin
			a = $urandom;
			b = $urandom;
			sa = 5'($urandom_range(0, 31));
			// sign-extended 33-bit forms expose overflow
			wide = {a[31], a} + {b[31], b};
			addTest($sformatf("addRnd%0d", i), execPkg::opAdd, a, b, sa, wide[31:0],
				wide[32] ^ wide[31]);
			addTest($sformatf("adduRnd%0d", i), execPkg::opAddu, a, b, sa, a + b, 1'b0);
			wide = {a[31], a} - {b[31], b};
			addTest($sformatf("subRnd%0d", i), execPkg::opSub, a, b, sa, wide[31:0],
				wide[32] ^ wide[31]);
			addTest($sformatf("subuRnd%0d", i), execPkg::opSubu, a, b, sa, a - b, 1'b0);
			addTest($sformatf("andRnd%0d", i), execPkg::opAnd, a, b, sa, a & b, 1'b0);
			addTest($sformatf("orRnd%0d", i), execPkg::opOr, a, b, sa, a | b, 1'b0);
			addTest($sformatf("xorRnd%0d", i), execPkg::opXor, a, b, sa, a ^ b, 1'b0);
			addTest($sformatf("norRnd%0d", i), execPkg::opNor, a, b, sa, ~(a | b), 1'b0);
			addTest($sformatf("sltRnd%0d", i), execPkg::opSlt, a, b, sa,
				{31'd0, $signed(a) < $signed(b)}, 1'b0);
			addTest($sformatf("sltuRnd%0d", i), execPkg::opSltu, a, b, sa, {31'd0, a < b}, 1'b0);
			addTest($sformatf("sllRnd%0d", i), execPkg::opSll, a, b, sa, b << sa, 1'b0);
			addTest($sformatf("srlRnd%0d", i), execPkg::opSrl, a, b, sa, b >> sa, 1'b0);
			addTest($sformatf("sraRnd%0d", i), execPkg::opSra, a, b, sa, $signed(b) >>> sa, 1'b0);
			addTest($sformatf("luiRnd%0d", i), execPkg::opLui, a, b, sa, {b[15:0], 16'h0}, 1'b0);
		end
		// multiply, negative srcA always, srcB negative on odd rows
		for (int i = 0; i < 3; i++) begin
			a = $urandom | 32'h8000_0000;
			b = $urandom;
			b[31] = i[0];
			prod = $signed(a) * $signed(b);
			addTest($sformatf("mult%0d", i), execPkg::opMult, a, b, 5'd0, 32'h0, 1'b0);
			addTest($sformatf("multHi%0d", i), execPkg::opMfhi, a, b, 5'd0, prod[63:32], 1'b0);
			addTest($sformatf("multLo%0d", i), execPkg::opMflo, a, b, 5'd0, prod[31:0], 1'b0);
			prod = {32'h0, a} * {32'h0, b};
			addTest($sformatf("multu%0d", i), execPkg::opMultu, a, b, 5'd0, 32'h0, 1'b0);
			addTest($sformatf("multuHi%0d", i), execPkg::opMfhi, a, b, 5'd0, prod[63:32], 1'b0);
			addTest($sformatf("multuLo%0d", i), execPkg::opMflo, a, b, 5'd0, prod[31:0], 1'b0);
		end
		// divide, remainder keeps the dividend sign
		for (int i = 0; i < 3; i++) begin
			a = $urandom;
			a[31] = (i != 2);
			b = 32'($urandom_range(1, 100000));
			if (i[0]) b = -b;
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
			addTest($sformatf("div%0d", i), execPkg::opDiv, a, b, 5'd0, 32'h0, 1'b0);
			addTest($sformatf("divLo%0d", i), execPkg::opMflo, a, b, 5'd0, q, 1'b0);
			addTest($sformatf("divHi%0d", i), execPkg::opMfhi, a, b, 5'd0, r, 1'b0);
			b = ($urandom >> 8) | 32'h1;
			addTest($sformatf("divu%0d", i), execPkg::opDivu, a, b, 5'd0, 32'h0, 1'b0);
			addTest($sformatf("divuLo%0d", i), execPkg::opMflo, a, b, 5'd0, a / b, 1'b0);
			addTest($sformatf("divuHi%0d", i), execPkg::opMfhi, a, b, 5'd0, a % b, 1'b0);
		end
		// zero divisor leaves mthi/mtlo values alone
		addTest("mthiSet", execPkg::opMthi, 32'h1234_5678, 32'h0, 5'd0, 32'h0, 1'b0);
		addTest("mtloSet", execPkg::opMtlo, 32'h9abc_def0, 32'h0, 5'd0, 32'h0, 1'b0);
		addTest("divZero", execPkg::opDiv, 32'h7, 32'h0, 5'd0, 32'h0, 1'b0);
		addTest("divuZero", execPkg::opDivu, 32'h7, 32'h0, 5'd0, 32'h0, 1'b0);
		addTest("zeroKeepsHi", execPkg::opMfhi, 32'h0, 32'h0, 5'd0, 32'h1234_5678, 1'b0);
		addTest("zeroKeepsLo", execPkg::opMflo, 32'h0, 32'h0, 5'd0, 32'h9abc_def0, 1'b0);
	endtask

	// ====================
	// main sequence
	// ====================

	initial begin
		void'($urandom(32'hf866_1097));
		clk = 1'b0;
		arstN = 1'b0;
		req = 1'b0;
		op = '0;
		buildTable();
		repeat (16) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkValue("ackAfterReset", 33'd0, {32'd0, ack});
		checkValue("resultAfterReset", 33'd0, result);
		foreach (testName[i]) runTest(i);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/execPkg.sv
logic/aluCore.sv
logic/mulDivUnit.sv
logic/writebackStage.sv
logic/execUnit.sv
tests/execUnitTb.sv

// File: run.sh
#!/bin/sh
# build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module execUnitTb \
	-f filelist.f -o execUnitSim

# the simulator exits non-zero on failure, the grep below decides
out=$(./obj_dir/execUnitSim 2>&1) || true
echo "$out"
echo "$out" | grep -q "TB PASSED"
